// ==== logic/div_pkg.sv ====
/*
  Shared types for the unsigned divider: FSM states and the command
  opcode sent from the control block to the datapath.
*/
package div_pkg;

  // Sequencing states of the handshake FSM
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_STEP = 2'd1,
    ST_FIX  = 2'd2,
    ST_DONE = 2'd3
  } div_state_e;

  // Datapath operations, one per clock
  typedef enum logic [1:0] {
    CMD_HOLD = 2'd0,
    CMD_LOAD = 2'd1,
    CMD_STEP = 2'd2,
    CMD_FIX  = 2'd3
  } div_cmd_e;

endpackage

// ==== logic/div_step_counter.sv ====
/*
  Iteration counter for the divider. Loaded with the operand width at the
  start of a division and decremented once per quotient bit.
*/
`timescale 1ns/100ps

module div_step_counter #(
  parameter int WIDTH = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic step,
  output logic last
);

  localparam int CW = $clog2(WIDTH) + 1;

  logic [CW-1:0] count;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= CW'(WIDTH);
    end else if (step) begin
      count <= count - 1'b1;
    end
  end

  // One iteration left
  assign last = (count == CW'(1));

  a_count_range: assert property (
    @(posedge clk) disable iff (rst) count <= CW'(WIDTH)
  );

  // Control must stop stepping once the count runs out
  a_no_step_at_zero: assert property (
    @(posedge clk) disable iff (rst) step |-> count != '0
  );

  a_step_progress: assert property (
    @(posedge clk) disable iff (rst) step |=> count == $past(count) - 1'b1
  );

  a_load_step_excl: assert property (
    @(posedge clk) disable iff (rst) !(load && step)
  );

endmodule

// ==== logic/div_ctrl.sv ====
/*
  Handshake FSM of the divider. Accepts a four-phase req/ack request, runs
  the load, step and fix sequence and holds ack until req is released.
*/
`timescale 1ns/100ps

module div_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  output logic              ack,
  output div_pkg::div_cmd_e cmd,
  output logic              cnt_load,
  output logic              cnt_step,
  input  logic              cnt_last
);

  import div_pkg::*;

  div_state_e state;
  div_state_e state_next;

  // Next state, datapath command and counter strobes
  always_comb begin
    state_next = state;
    cmd        = CMD_HOLD;
    cnt_load   = 1'b0;
    cnt_step   = 1'b0;
    case (state)
      ST_IDLE: begin
        if (req) begin
          cmd        = CMD_LOAD;
          cnt_load   = 1'b1;
          state_next = ST_STEP;
        end
      end
      ST_STEP: begin
        cmd      = CMD_STEP;
        cnt_step = 1'b1;
        if (cnt_last) begin
          state_next = ST_FIX;
        end
      end
      ST_FIX: begin
        cmd        = CMD_FIX;
        state_next = ST_DONE;
      end
      ST_DONE: begin
        // Result held until the requester lets go of req
        if (!req) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_IDLE;
      ack   <= 1'b0;
    end else begin
      state <= state_next;
      ack   <= (state_next == ST_DONE);
    end
  end

  // Ack only comes up after the correction cycle
  a_ack_rise_from_fix: assert property (
    @(posedge clk) disable iff (rst) $rose(ack) |-> $past(state) == ST_FIX
  );

  a_ack_fall_after_req: assert property (
    @(posedge clk) disable iff (rst) $fell(ack) |-> !$past(req)
  );

  // A new division never starts on top of a held result
  a_no_load_during_ack: assert property (
    @(posedge clk) disable iff (rst) cmd == CMD_LOAD |-> !ack
  );

endmodule

// ==== logic/div_datapath.sv ====
/*
  Non-restoring divider datapath. Holds the partial remainder, the combined
  dividend/quotient shift register and the divisor, and executes the command
  from the control FSM each clock.
*/
`timescale 1ns/100ps

module div_datapath #(
  parameter int WIDTH = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  div_pkg::div_cmd_e cmd,
  input  logic [WIDTH-1:0]  dividend,
  input  logic [WIDTH-1:0]  divisor,
  output logic [WIDTH-1:0]  quotient,
  output logic [WIDTH-1:0]  remainder
);

  import div_pkg::*;

  // Partial remainder with its sign in the MSB
  logic [WIDTH:0]   rem;
  // Dividend bits shift out at the top, quotient bits enter at the bottom
  logic [WIDTH-1:0] quo_shift;
  logic [WIDTH-1:0] dvs;

  logic [WIDTH:0]   dvs_ext;
  logic [WIDTH:0]   rem_shift;
  logic [WIDTH:0]   rem_step;
  logic [WIDTH:0]   rem_fix;

  assign dvs_ext = {1'b0, dvs};

  // Bring down the next dividend bit
  // The old sign can go since every step result fits in WIDTH+1 bits
  assign rem_shift = {rem[WIDTH-1:0], quo_shift[WIDTH-1]};

  // Subtract while non-negative, add back while negative
  always_comb begin
    if (rem[WIDTH]) begin
      rem_step = rem_shift + dvs_ext;
    end else begin
      rem_step = rem_shift - dvs_ext;
    end
  end

  // Final correction of a negative remainder
  always_comb begin
    if (rem[WIDTH]) begin
      rem_fix = rem + dvs_ext;
    end else begin
      rem_fix = rem;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rem       <= '0;
      quo_shift <= '0;
      dvs       <= '0;
    end else begin
      case (cmd)
        CMD_LOAD: begin
          rem       <= '0;
          quo_shift <= dividend;
          dvs       <= divisor;
        end
        CMD_STEP: begin
          rem       <= rem_step;
          // Quotient bit is set when the new remainder is non-negative
          quo_shift <= {quo_shift[WIDTH-2:0], ~rem_step[WIDTH]};
        end
        CMD_FIX: begin
          rem <= rem_fix;
        end
        default: begin
          rem <= rem;
        end
      endcase
    end
  end

  assign quotient  = quo_shift;
  assign remainder = rem[WIDTH-1:0];

  a_no_unknown: assert property (
    @(posedge clk) disable iff (rst) !$isunknown({rem, quo_shift, dvs})
  );

  // Divisor must survive the whole iteration sequence
  a_divisor_stable: assert property (
    @(posedge clk) disable iff (rst)
      cmd == CMD_LOAD |-> ##(WIDTH + 1)
        (cmd == CMD_FIX && dvs == $past(divisor, WIDTH + 1))
  );

  // After correction the remainder is a proper one
  a_rem_in_range: assert property (
    @(posedge clk) disable iff (rst)
      (cmd == CMD_FIX && dvs != '0) |=> (!rem[WIDTH] && rem[WIDTH-1:0] < dvs)
  );

endmodule

// ==== logic/unsigned_divider.sv ====
/*
  Top level of the unsigned divider with a four-phase req/ack handshake.
  Ties together the control FSM, the step counter and the datapath.
*/
`timescale 1ns/100ps

module unsigned_divider #(
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             req,
  output logic             ack,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder
);

  import div_pkg::*;

  div_cmd_e cmd;
  logic     cnt_load;
  logic     cnt_step;
  logic     cnt_last;

  div_ctrl i_div_ctrl (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .cmd      (cmd),
    .cnt_load (cnt_load),
    .cnt_step (cnt_step),
    .cnt_last (cnt_last)
  );

  div_step_counter #(
    .WIDTH (WIDTH)
  ) i_div_step_counter (
    .clk  (clk),
    .rst  (rst),
    .load (cnt_load),
    .step (cnt_step),
    .last (cnt_last)
  );

  div_datapath #(
    .WIDTH (WIDTH)
  ) i_div_datapath (
    .clk       (clk),
    .rst       (rst),
    .cmd       (cmd),
    .dividend  (dividend),
    .divisor   (divisor),
    .quotient  (quotient),
    .remainder (remainder)
  );

endmodule

// ==== verification/tb_div_vectors.svh ====
/*
  Directed operand table for the divider testbench, included inside the
  testbench module. Each row is a test name, a dividend and a divisor.
*/
`ifndef TB_DIV_VECTORS_SVH
`define TB_DIV_VECTORS_SVH

localparam int NUM_ROWS = 14;

string            row_name     [NUM_ROWS];
logic [WIDTH-1:0] row_dividend [NUM_ROWS];
logic [WIDTH-1:0] row_divisor  [NUM_ROWS];

task automatic set_row(input int idx, input string name,
                       input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b);
  row_name[idx]     = name;
  row_dividend[idx] = a;
  row_divisor[idx]  = b;
endtask

// One call per row with index, test name, dividend and divisor
task automatic build_vector_table();
  set_row(0,  "divisor_one",      200, 1);
  set_row(1,  "one_by_one",       1,   1);
  set_row(2,  "equal_operands",   173, 173);
  set_row(3,  "divisor_greater",  25,  90);
  set_row(4,  "dividend_zero",    0,   37);
  set_row(5,  "all_ones",         255, 255);
  set_row(6,  "max_by_one",       255, 1);
  set_row(7,  "power_of_two",     201, 16);
  set_row(8,  "top_bit_divisor",  255, 128);
  set_row(9,  "divide_by_zero",   123, 0);
  set_row(10, "zero_by_zero",     0,   0);
  set_row(11, "max_by_zero",      255, 0);
  set_row(12, "small_by_three",   100, 3);
  set_row(13, "large_by_seven",   250, 7);
endtask

`endif

// ==== verification/tb_unsigned_divider.sv ====
/*
  Testbench for the unsigned divider. Runs the directed table and a set of
  random operand pairs through the req/ack handshake against a reference model.
*/
`timescale 1ns/100ps

module tb_unsigned_divider;

  localparam int WIDTH      = 8;
  localparam int CLK_PERIOD = 4;
  localparam int NUM_RANDOM = 200;

  `include "tb_div_vectors.svh"

  logic             clk;
  logic             rst;
  logic             req;
  logic             ack;
  logic [WIDTH-1:0] dividend;
  logic [WIDTH-1:0] divisor;
  logic [WIDTH-1:0] quotient;
  logic [WIDTH-1:0] remainder;

  logic [31:0]      rng_state;

  unsigned_divider #(
    .WIDTH (WIDTH)
  ) i_unsigned_divider (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .ack       (ack),
    .dividend  (dividend),
    .divisor   (divisor),
    .quotient  (quotient),
    .remainder (remainder)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Zero divisor gives all ones and keeps the dividend as remainder
  function automatic logic [WIDTH-1:0] ref_quotient(input logic [WIDTH-1:0] a,
                                                    input logic [WIDTH-1:0] b);
    if (b == '0) begin
      return '1;
    end
    return a / b;
  endfunction

  function automatic logic [WIDTH-1:0] ref_remainder(input logic [WIDTH-1:0] a,
                                                     input logic [WIDTH-1:0] b);
    if (b == '0) begin
      return a;
    end
    return a % b;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("error: test %s, %s: expected %0h, actual %0h",
                         test_name, what, expected, actual));
    end
  endtask

  // Full four-phase transaction, entered and left on a falling edge with ack low
  task automatic run_division(input string name, input logic [WIDTH-1:0] a,
                              input logic [WIDTH-1:0] b, input int hold);
    logic [WIDTH-1:0] exp_q;
    logic [WIDTH-1:0] exp_r;
    int               edges;
    exp_q    = ref_quotient(a, b);
    exp_r    = ref_remainder(a, b);
    dividend = a;
    divisor  = b;
    req      = 1'b1;
    edges    = 0;
    while (!ack && edges < 4 * WIDTH) begin
      @(negedge clk);
      edges++;
    end
    if (!ack) begin
      fail_run($sformatf("ack never came for test %s", name));
    end
    // First counted edge is the one that sampled req
    check_value(name, "ack latency", WIDTH + 1, edges - 1);
    check_value(name, "quotient", exp_q, quotient);
    check_value(name, "remainder", exp_r, remainder);

    // Operands may change once the result is acknowledged
    dividend = ~a;
    divisor  = ~b;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_value(name, "ack during hold", 1, ack);
      check_value(name, "quotient during hold", exp_q, quotient);
      check_value(name, "remainder during hold", exp_r, remainder);
    end

    req = 1'b0;
    @(negedge clk);
    check_value(name, "ack after req drop", 0, ack);
    check_value(name, "quotient after release", exp_q, quotient);
    check_value(name, "remainder after release", exp_r, remainder);
  endtask

  // Watchdog sized for the worst case of every transaction
  initial begin
    #(CLK_PERIOD * ((NUM_ROWS + NUM_RANDOM) * (WIDTH + 6) + 8));
    fail_run("timeout: the test sequence did not finish in time");
  end

  initial begin
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    rst       = 1'b1;
    req       = 1'b0;
    dividend  = '0;
    divisor   = '0;
    rng_state = 32'ha31e_42d9;
    build_vector_table();

    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("reset", "ack", 0, ack);
    check_value("reset", "quotient", 0, quotient);
    check_value("reset", "remainder", 0, remainder);

    // Directed rows with a hold time that varies from row to row
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_division(row_name[i], row_dividend[i], row_divisor[i], i % 4);
    end

    // Back to back random pairs that favor smaller divisors
    for (int i = 0; i < NUM_RANDOM; i++) begin
      rng_state = xorshift32(rng_state);
      a = rng_state[WIDTH-1:0];
      b = rng_state[23:16] >> rng_state[26:24];
      run_division($sformatf("random_%0d", i), a, b, 0);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+verification
logic/div_pkg.sv
logic/div_step_counter.sv
logic/div_ctrl.sv
logic/div_datapath.sv
logic/unsigned_divider.sv
verification/tb_unsigned_divider.sv
